// File: all.f
+incdir+rtl
rtl/lc_env_pkg.sv
rtl/lc_rd_port.sv
rtl/lc_pwr_seq.sv
rtl/lc_clk_esc_ctrl.sv
rtl/lc_env_top.sv
verification/lc_env_properties.sv
verification/lc_env_tb.sv

// File: Makefile
# Verilator flow for the lifecycle environment testbench
.PHONY: all run lint clean

all: run

obj_dir/Vlc_env_tb: all.f $(wildcard rtl/*) $(wildcard verification/*)
	verilator --binary --timing --assert -Wno-fatal --top-module lc_env_tb -f all.f -o Vlc_env_tb

run: obj_dir/Vlc_env_tb
	./obj_dir/Vlc_env_tb | tee run.log
	grep -q "All tests passed!" run.log

lint:
	verilator --lint-only -Wall --timing --top-module lc_env_tb -f all.f

clean:
	rm -rf obj_dir run.log

// File: verification/lc_env_tb.sv
// Self-checking testbench for lc_env_top, reads no file and dumps no waves
// Cycle model advances on each rising edge, outputs compared on the falling edge
// Stimulus moves 1 ns after the rising edge
`timescale 1ns/10ps
`include "lc_env_defines.svh"

module lc_env_tb;

    import lc_env_pkg::*;

    localparam int N_READS = 200;
    localparam int TIMEOUT = 10 * `LC_INIT_WAIT + N_READS * 8;

    logic                      clk = 1'b0;
    logic                      reset_n = 1'b0;
    logic                      pwrgood_i = 1'b1;
    logic                      arvalid_i = 1'b0;
    logic [`LC_ADDR_W-1:0]     araddr_i = '0;
    logic                      arready_o;
    logic                      rvalid_o;
    logic [31:0]               rdata_o;
    logic                      rready_i = 1'b0;
    lc_tx_t                    lc_clk_byp_req_i = LC_OFF;
    lc_tx_t                    lc_clk_byp_ack_o;
    logic [`LC_NUM_ALERTS-1:0] alerts_i = '0;
    logic                      esc_scrap0_o;
    logic                      esc_scrap1_o;
    logic                      rma_strap_o;
    logic                      lc_init_o;
    logic                      sys_rst_n_o;

    // Reference model, starts at the after-reset values
    logic        rvalid_m = 1'b0;
    logic [31:0] rdata_m = '0;
    logic        acc_m = 1'b0;
    logic        strap_m = 1'b0;
    logic        init_m = 1'b0;
    logic        sys_rst_n_m = 1'b1;
    logic        esc_m = 1'b0;
    lc_tx_t      ack_m = LC_OFF;
    int          wait_m = 0;
    int          pend_m = 0;

    int          errors = 0;
    int          accepts = 0;
    int          responses = 0;
    int          cycles = 0;
    logic [31:0] rnd = 32'h8479;

    lc_env_top i_lc_env_top (.*);

    bind lc_env_top lc_env_properties i_lc_env_properties (.*);

    always #50 clk = !clk;

    function automatic logic [31:0] next_rand();
        rnd = rnd ^ (rnd << 13);
        rnd = rnd ^ (rnd >> 17);
        rnd = rnd ^ (rnd << 5);
        return rnd;
    endfunction

    // Expected read data from the modelled status
    function automatic logic [31:0] ref_read(input logic [31:0] addr);
        logic [31:0] status;
        status = {28'd0, esc_m, init_m, sys_rst_n_m, strap_m};
        if ((addr == `LC_STATUS_ADDR) || (addr == `LC_STRAP_ADDR)) begin
            return status;
        end
        return 32'd0;
    endfunction

    // Mostly magic addresses, some random ones
    function automatic logic [31:0] pick_addr();
        logic [31:0] r;
        r = next_rand();
        case (r[2:0])
            3'd0, 3'd1, 3'd2: return `LC_STATUS_ADDR;
            3'd3:             return `LC_STRAP_ADDR;
            3'd4:             return `LC_RESET_ADDR;
            default:          return next_rand();
        endcase
    endfunction

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("Mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    // One clock, then fresh back-pressure, bypass request and alerts
    task automatic step_cycle();
        logic [31:0] r;
        @(posedge clk);
        #1;
        r = next_rand();
        rready_i = (r[1:0] != 2'd0);
        if (r[6:4] == 3'd0) begin
            lc_clk_byp_req_i = (lc_clk_byp_req_i == LC_ON) ? LC_OFF : LC_ON;
        end
        alerts_i = (r[9:8] == 2'd0) ? r[12 +: `LC_NUM_ALERTS] : '0;
    endtask

    // Holds the address until the model sees it accepted
    task automatic issue_read(input logic [31:0] addr);
        arvalid_i = 1'b1;
        araddr_i  = addr;
        do begin
            step_cycle();
        end while (!acc_m);
        arvalid_i = 1'b0;
    endtask

    // ------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------
    always @(posedge clk) begin
        if (reset_n) begin
            acc_m = arvalid_i && !rvalid_m;
            if (acc_m) begin
                rdata_m = ref_read(araddr_i);
                accepts++;
            end
            rvalid_m = acc_m || (rvalid_m && !rready_i);
            if (acc_m && (araddr_i == `LC_STRAP_ADDR)) begin
                strap_m = !strap_m;
            end
            // Sequencer frozen without power-good
            if (pwrgood_i) begin
                if (!init_m) begin
                    wait_m++;
                    if (wait_m == `LC_INIT_WAIT) begin
                        init_m      = 1'b1;
                        sys_rst_n_m = 1'b1;
                        wait_m      = 0;
                    end
                end else if (pend_m != 0) begin
                    pend_m--;
                    if (pend_m == 0) begin
                        init_m      = 1'b0;
                        sys_rst_n_m = 1'b0;
                    end
                end else if (acc_m && (araddr_i == `LC_RESET_ADDR)) begin
                    // Drop lands LC_RST_DELAY + 2 cycles from the accept cycle
                    pend_m = `LC_RST_DELAY + 1;
                end
            end
            ack_m = ((lc_clk_byp_req_i == LC_ON) && (ack_m == LC_OFF)) ? LC_ON : LC_OFF;
            esc_m = |alerts_i;
        end
    end

    // Comparator
    always @(negedge clk) begin
        if (reset_n) begin
            compare_field("arready_o", arready_o, !rvalid_m);
            compare_field("rvalid_o", rvalid_o, rvalid_m);
            if (rvalid_m) begin
                compare_field("rdata_o", rdata_o, rdata_m);
            end
            compare_field("rma_strap_o", rma_strap_o, strap_m);
            compare_field("lc_init_o", lc_init_o, init_m);
            compare_field("sys_rst_n_o", sys_rst_n_o, sys_rst_n_m);
            compare_field("lc_clk_byp_ack_o", lc_clk_byp_ack_o, ack_m);
            compare_field("esc_scrap0_o", esc_scrap0_o, esc_m);
            compare_field("esc_scrap1_o", esc_scrap1_o, esc_m);
            if (rvalid_o && rready_i) begin
                responses++;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > TIMEOUT) begin
            $display("Run did not finish within %0d cycles, %0d errors", TIMEOUT, errors);
            $display("Test failures found");
            $finish;
        end
    end

    // ------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------
    initial begin
        repeat (2) @(posedge clk);
        #1;
        reset_n = 1'b1;

        // Power-good dropout in the first wait pushes lc_init out
        repeat (100) step_cycle();
        pwrgood_i = 1'b0;
        repeat (30) step_cycle();
        pwrgood_i = 1'b1;
        while (!lc_init_o) step_cycle();

        for (int i = 0; i < N_READS; i++) begin
            repeat (next_rand() % 3) step_cycle();
            issue_read(pick_addr());
        end

        // Quiet ready state, any earlier request has played out
        while (!lc_init_o) step_cycle();
        repeat (`LC_RST_DELAY + 2) step_cycle();
        while (!lc_init_o) step_cycle();
        issue_read(`LC_RESET_ADDR);
        repeat (5) step_cycle();
        // Second request while pending, then one in the wait
        issue_read(`LC_RESET_ADDR);
        while (lc_init_o) step_cycle();
        issue_read(`LC_RESET_ADDR);
        while (!lc_init_o) step_cycle();

        issue_read(`LC_STATUS_ADDR);
        issue_read(`LC_STRAP_ADDR);
        issue_read(`LC_STATUS_ADDR);
        while (rvalid_m) step_cycle();
        step_cycle();

        assert (accepts == responses) else begin
            errors++;
            $display("Accepted %0d addresses but saw %0d responses", accepts, responses);
        end
        $display("Errors: %0d, reads accepted: %0d, responses: %0d", errors, accepts, responses);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: verification/lc_env_properties.sv
// Concurrent checks on lc_env_top, attached by bind from the testbench
// All checks are idle while reset_n is low
`timescale 1ns/10ps

module lc_env_properties (
    input logic               clk,
    input logic               reset_n,
    input logic               arready_o,
    input logic               rvalid_o,
    input logic [31:0]        rdata_o,
    input logic               rready_i,
    input lc_env_pkg::lc_tx_t lc_clk_byp_ack_o,
    input logic               lc_init_o,
    input logic               sys_rst_n_o
);

    import lc_env_pkg::*;

    logic init_seen_q;

    // Set by the first rise of lc_init_o
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            init_seen_q <= 1'b0;
        end else if (lc_init_o) begin
            init_seen_q <= 1'b1;
        end
    end

    // ------------------------------------------------------------
    // Read channel
    // ------------------------------------------------------------
    assert property (@(posedge clk) disable iff (!reset_n)
        (rvalid_o && !rready_i) |=> (rvalid_o && $stable(rdata_o)))
        else $error("Read response changed while rready_i was low");

    assert property (@(posedge clk) disable iff (!reset_n) rvalid_o |-> !arready_o)
        else $error("arready_o high while a response is pending");

    // ------------------------------------------------------------
    // Bypass ack and sequencer outputs
    // ------------------------------------------------------------
    assert property (@(posedge clk) disable iff (!reset_n)
        (lc_clk_byp_ack_o == LC_ON) |=> (lc_clk_byp_ack_o != LC_ON))
        else $error("Bypass ack held at LC_ON for two cycles");

    // Both outputs move in the same cycle once the first init is done
    assert property (@(posedge clk) disable iff (!reset_n)
        init_seen_q |-> ((lc_init_o != $past(lc_init_o)) == (sys_rst_n_o != $past(sys_rst_n_o))))
        else $error("lc_init_o and sys_rst_n_o changed in different cycles");

endmodule

// File: rtl/lc_env_top.sv
// Lifecycle environment top level
// Status word reflects escalation one cycle after the alerts arrive
// Only the read channel is present, no write path
`timescale 1ns/10ps
`include "lc_env_defines.svh"

module lc_env_top (
    input  logic                       clk,
    input  logic                       reset_n,
    input  logic                       pwrgood_i,
    // Read channel
    input  logic                       arvalid_i,
    input  logic [`LC_ADDR_W-1:0]      araddr_i,
    output logic                       arready_o,
    output logic                       rvalid_o,
    output logic [31:0]                rdata_o,
    input  logic                       rready_i,
    // Clock bypass
    input  lc_env_pkg::lc_tx_t         lc_clk_byp_req_i,
    output lc_env_pkg::lc_tx_t         lc_clk_byp_ack_o,
    // Alerts and escalation
    input  logic [`LC_NUM_ALERTS-1:0]  alerts_i,
    output logic                       esc_scrap0_o,
    output logic                       esc_scrap1_o,
    // Lifecycle state outputs
    output logic                       rma_strap_o,
    output logic                       lc_init_o,
    output logic                       sys_rst_n_o
);

    logic rst_req;
    logic esc_any;

    // Either escalation copy marks the status word
    assign esc_any = esc_scrap0_o | esc_scrap1_o;

    // ------------------------------------------------------------
    // Read port
    // ------------------------------------------------------------
    lc_rd_port i_lc_rd_port (
        .clk         (clk),
        .reset_n     (reset_n),
        .arvalid_i   (arvalid_i),
        .araddr_i    (araddr_i),
        .arready_o   (arready_o),
        .rvalid_o    (rvalid_o),
        .rdata_o     (rdata_o),
        .rready_i    (rready_i),
        .lc_init_i   (lc_init_o),
        .sys_rst_n_i (sys_rst_n_o),
        .esc_i       (esc_any),
        .rst_req_o   (rst_req),
        .rma_strap_o (rma_strap_o)
    );

    // Sequencer sees the reset pulse in the accept cycle
    lc_pwr_seq i_lc_pwr_seq (
        .clk         (clk),
        .reset_n     (reset_n),
        .pwrgood_i   (pwrgood_i),
        .rst_req_i   (rst_req),
        .lc_init_o   (lc_init_o),
        .sys_rst_n_o (sys_rst_n_o)
    );

    // ------------------------------------------------------------
    // Clock bypass and escalation
    // ------------------------------------------------------------
    lc_clk_esc_ctrl i_lc_clk_esc_ctrl (
        .clk              (clk),
        .reset_n          (reset_n),
        .lc_clk_byp_req_i (lc_clk_byp_req_i),
        .lc_clk_byp_ack_o (lc_clk_byp_ack_o),
        .alerts_i         (alerts_i),
        .esc_scrap0_o     (esc_scrap0_o),
        .esc_scrap1_o     (esc_scrap1_o)
    );

endmodule

// File: rtl/lc_clk_esc_ctrl.sv
// Clock bypass ack and alert escalation
// Ack pulses every second cycle while the request stays at LC_ON
// Escalation outputs are not sticky and follow alerts one cycle late
`timescale 1ns/10ps
`include "lc_env_defines.svh"

module lc_clk_esc_ctrl (
    input  logic                       clk,
    input  logic                       reset_n,
    input  lc_env_pkg::lc_tx_t         lc_clk_byp_req_i,
    output lc_env_pkg::lc_tx_t         lc_clk_byp_ack_o,
    input  logic [`LC_NUM_ALERTS-1:0]  alerts_i,
    output logic                       esc_scrap0_o,
    output logic                       esc_scrap1_o
);

    import lc_env_pkg::*;

    lc_tx_t ack_q;
    logic   esc0_q;
    logic   esc1_q;

    // ------------------------------------------------------------
    // Bypass handshake
    // ------------------------------------------------------------
    // Ack only from LC_OFF so it can never stay on two cycles
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            ack_q <= LC_OFF;
        end else if ((lc_clk_byp_req_i == LC_ON) && (ack_q == LC_OFF)) begin
            ack_q <= LC_ON;
        end else begin
            ack_q <= LC_OFF;
        end
    end

    // ------------------------------------------------------------
    // Escalation
    // ------------------------------------------------------------
    // Two separate flops on purpose, redundant copies of the same alert
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            esc0_q <= 1'b0;
            esc1_q <= 1'b0;
        end else begin
            esc0_q <= |alerts_i;
            esc1_q <= |alerts_i;
        end
    end

    assign lc_clk_byp_ack_o = ack_q;
    assign esc_scrap0_o     = esc0_q;
    assign esc_scrap1_o     = esc1_q;

endmodule

// File: rtl/lc_pwr_seq.sv
// Power sequencer, all state holds while pwrgood_i is low
// Reset requests count only in SEQ_READY, others are dropped silently
// Request to drop of lc_init_o is LC_RST_DELAY + 2 cycles from the accept
`timescale 1ns/10ps
`include "lc_env_defines.svh"

module lc_pwr_seq (
    input  logic clk,
    input  logic reset_n,
    input  logic pwrgood_i,
    input  logic rst_req_i,
    output logic lc_init_o,
    output logic sys_rst_n_o
);

    import lc_env_pkg::*;

    localparam int unsigned CNT_W = $clog2(`LC_INIT_WAIT + 1);
    localparam logic [CNT_W-1:0] WAIT_LAST = CNT_W'(`LC_INIT_WAIT - 1);

    pwr_seq_state_t            state_q;
    logic [CNT_W-1:0]          wait_cnt_q;
    logic [`LC_RST_DELAY-1:0]  dly_q;
    logic                      dly_out_q;
    logic                      sys_rst_n_q;
    logic                      req_take;

    // Request enters the delay line only from the ready state
    assign req_take = rst_req_i && (state_q == SEQ_READY);

    // ------------------------------------------------------------
    // Request delay line
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            dly_q     <= '0;
            dly_out_q <= 1'b0;
        end else if (pwrgood_i) begin
            dly_q     <= {dly_q[`LC_RST_DELAY-2:0], req_take};
            // Extra stage after the line
            dly_out_q <= dly_q[`LC_RST_DELAY-1];
        end
    end

    // ------------------------------------------------------------
    // Sequencer FSM and init wait counter
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state_q     <= SEQ_INIT_WAIT;
            wait_cnt_q  <= '0;
            // System reset stays released during the first wait
            sys_rst_n_q <= 1'b1;
        end else if (pwrgood_i) begin
            unique case (state_q)
                SEQ_INIT_WAIT: begin
                    if (wait_cnt_q == WAIT_LAST) begin
                        wait_cnt_q  <= '0;
                        state_q     <= SEQ_READY;
                        // Released together with lc_init
                        sys_rst_n_q <= 1'b1;
                    end else begin
                        wait_cnt_q <= wait_cnt_q + 1'b1;
                    end
                end
                SEQ_READY: begin
                    if (req_take) begin
                        state_q <= SEQ_RST_PEND;
                    end
                end
                SEQ_RST_PEND: begin
                    // End of the line starts the re-init window
                    if (dly_out_q) begin
                        state_q     <= SEQ_INIT_WAIT;
                        wait_cnt_q  <= '0;
                        sys_rst_n_q <= 1'b0;
                    end
                end
                default: begin
                    state_q <= SEQ_INIT_WAIT;
                end
            endcase
        end
    end

    // lc_init high whenever the init wait is over
    assign lc_init_o   = (state_q != SEQ_INIT_WAIT);
    assign sys_rst_n_o = sys_rst_n_q;

endmodule

// File: rtl/lc_rd_port.sv
// Read-only AXI-lite style slave with one read outstanding at a time
// Magic addresses act on the accept edge, response follows one cycle later
// Unknown addresses read as zero and never raise an error response
`timescale 1ns/10ps
`include "lc_env_defines.svh"

module lc_rd_port (
    input  logic                  clk,
    input  logic                  reset_n,
    // Read address channel
    input  logic                  arvalid_i,
    input  logic [`LC_ADDR_W-1:0] araddr_i,
    output logic                  arready_o,
    // Read data channel
    output logic                  rvalid_o,
    output logic [31:0]           rdata_o,
    input  logic                  rready_i,
    // Status sources
    input  logic                  lc_init_i,
    input  logic                  sys_rst_n_i,
    input  logic                  esc_i,
    // Side effects of magic reads
    output logic                  rst_req_o,
    output logic                  rma_strap_o
);

    logic        rvalid_q;
    logic [31:0] rdata_q;
    logic        strap_q;
    logic        ar_accept;
    logic [31:0] status_word;

    // ------------------------------------------------------------
    // Handshake
    // ------------------------------------------------------------
    // Address side closed while a response is pending
    assign arready_o = !rvalid_q;
    assign ar_accept = arvalid_i && arready_o;

    // Strap in bit 0, escalation summary in bit 3
    assign status_word = {28'd0, esc_i, lc_init_i, sys_rst_n_i, strap_q};

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rvalid_q <= 1'b0;
        end else if (ar_accept) begin
            rvalid_q <= 1'b1;
        end else if (rvalid_q && rready_i) begin
            rvalid_q <= 1'b0;
        end
    end

    // Response payload captured at the accept, held under back-pressure
    always_ff @(posedge clk) begin
        if (ar_accept) begin
            case (araddr_i)
                `LC_STATUS_ADDR: rdata_q <= status_word;
                // Old strap value goes back to the master
                `LC_STRAP_ADDR:  rdata_q <= status_word;
                default:         rdata_q <= 32'd0;
            endcase
        end
    end

    // ------------------------------------------------------------
    // Magic address side effects
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            strap_q <= 1'b0;
        end else if (ar_accept && (araddr_i == `LC_STRAP_ADDR)) begin
            strap_q <= !strap_q;
        end
    end

    // Single-cycle pulse, the sequencer decides whether it counts
    assign rst_req_o = ar_accept && (araddr_i == `LC_RESET_ADDR);

    assign rvalid_o    = rvalid_q;
    assign rdata_o     = rdata_q;
    assign rma_strap_o = strap_q;

endmodule

// File: rtl/lc_env_pkg.sv
// Types shared by the lifecycle environment blocks
// lc_tx_t uses a complementary 4-bit encoding, any other value is invalid
package lc_env_pkg;

    // ------------------------------------------------------------
    // Hardened lifecycle boolean
    // ------------------------------------------------------------
    // Single-bit flips never turn one legal value into the other
    typedef enum logic [3:0] {
        LC_ON  = 4'b1010,
        LC_OFF = 4'b0101
    } lc_tx_t;

    // ------------------------------------------------------------
    // Power sequencer states
    // ------------------------------------------------------------
    // Init wait after reset or after a requested re-init
    // Ready state is the only one that takes a reset request
    // Pending while the request walks down the delay line
    typedef enum logic [1:0] {
        SEQ_INIT_WAIT = 2'd0,
        SEQ_READY     = 2'd1,
        SEQ_RST_PEND  = 2'd2
    } pwr_seq_state_t;

endpackage

// File: rtl/lc_env_defines.svh
// Shared sizes and magic addresses for the lifecycle environment
// LC_RST_DELAY must be at least 2 and LC_INIT_WAIT at least 1
// Magic addresses assume a 32-bit read address
`ifndef LC_ENV_DEFINES_SVH
`define LC_ENV_DEFINES_SVH

// ------------------------------------------------------------
// Read bus
// ------------------------------------------------------------
`define LC_ADDR_W 32

// Status word location
`define LC_STATUS_ADDR 32'h7000_0440
// Read here requests a re-init of the subsystem
`define LC_RESET_ADDR 32'h7000_0444
// Read here flips the RMA strap
`define LC_STRAP_ADDR 32'h7000_0448

// ------------------------------------------------------------
// Power sequencer and escalation
// ------------------------------------------------------------
// Power-good cycles before lc_init is raised
`define LC_INIT_WAIT 500
// Stages in the reset request delay line
`define LC_RST_DELAY 20
`define LC_NUM_ALERTS 3

`endif
